/* logic/arbiter_pkg.sv */
package arbiter_pkg;

  // largest supported number of requesters.
  localparam int ARBITER_MAX_REQUESTS = 16;

  // bit positions in the ENABLE_ARBITER parameter.
  localparam int ARBITER_ENABLE_FIXED = 0;
  localparam int ARBITER_ENABLE_RR    = 1;

  // lowest index wins, or rotate after each grant.
  typedef enum logic [0:0] {
    ARBITER_FIXED       = 1'b0,
    ARBITER_ROUND_ROBIN = 1'b1
  } arbiter_mode_e;

  typedef struct packed {
    arbiter_mode_e mode;
  } arbiter_config_t;

  // wide enough to index any requester.
  typedef logic [$clog2(ARBITER_MAX_REQUESTS)-1:0] arbiter_index_t;

  // grant width for a given requester count and encoding.
  function automatic int calc_grant_width(
    int requests,
    bit onehot_grant
  );
    int width;
    if (onehot_grant) begin
      width = requests;
    end
    else if (requests <= 1) begin
      width = 1;
    end
    else begin
      width = $clog2(requests);
    end
    return width;
  endfunction

  // binary index of a one-hot mask, zero when empty.
  function automatic arbiter_index_t onehot_to_index(
    logic [ARBITER_MAX_REQUESTS-1:0] onehot
  );
    arbiter_index_t index;
    index = '0;
    for (int i = 0; i < ARBITER_MAX_REQUESTS; i++) begin
      if (onehot[i]) begin
        index = index | arbiter_index_t'(i);
      end
    end
    return index;
  endfunction

endpackage

/* logic/arbiter_if.sv */
`timescale 1ns/1ps

interface arbiter_if #(
  parameter int REQUESTS    = 4,
  parameter int GRANT_WIDTH = 4
);
  import arbiter_pkg::*;

  arbiter_config_t        arb_config;
  logic [REQUESTS-1:0]    request;
  logic [REQUESTS-1:0]    free;
  logic [GRANT_WIDTH-1:0] grant;
  logic                   active;

  // side that raises requests and releases grants.
  modport requester (
    output arb_config,
    output request,
    output free,
    input  grant,
    input  active
  );

  modport arbiter (
    input  arb_config,
    input  request,
    input  free,
    output grant,
    output active
  );

endinterface

/* logic/arbiter_select.sv */
`timescale 1ns/1ps

module arbiter_select #(
  parameter int REQUESTS = 4
)(
  input  var logic                       i_clk,
  input  var logic                       i_rst,
  input  var arbiter_pkg::arbiter_mode_e i_mode,
  input  var logic [REQUESTS-1:0]        i_request,
  input  var logic                       i_update,
  output var logic [REQUESTS-1:0]        o_winner
);
  import arbiter_pkg::*;

  arbiter_index_t      pointer;
  arbiter_index_t      winner_index;
  arbiter_index_t      pointer_next;
  logic [REQUESTS-1:0] upper_mask;
  logic [REQUESTS-1:0] upper_request;
  logic [REQUESTS-1:0] fixed_winner;
  logic [REQUESTS-1:0] rr_winner;

  // lowest set bit as a one-hot mask.
  function automatic logic [REQUESTS-1:0] lowest_set(
    logic [REQUESTS-1:0] bits
  );
    logic [REQUESTS-1:0] result;
    result = '0;
    for (int i = REQUESTS - 1; i >= 0; i--) begin
      if (bits[i]) begin
        result    = '0;
        result[i] = 1'b1;
      end
    end
    return result;
  endfunction

  always_comb begin
    fixed_winner = lowest_set(i_request);
  end

  // requests at or above the pointer.
  always_comb begin
    for (int i = 0; i < REQUESTS; i++) begin
      upper_mask[i] = (i >= int'(pointer));
    end
  end

  assign upper_request = i_request & upper_mask;

  // search upward from the pointer, then wrap to the bottom.
  always_comb begin
    if (upper_request != '0) begin
      rr_winner = lowest_set(upper_request);
    end
    else begin
      rr_winner = lowest_set(i_request);
    end
  end

  always_comb begin
    if (i_mode == ARBITER_ROUND_ROBIN) begin
      o_winner = rr_winner;
    end
    else begin
      o_winner = fixed_winner;
    end
  end

  assign winner_index = onehot_to_index(ARBITER_MAX_REQUESTS'(o_winner));

  // one past the winner, wrapping at the last requester.
  always_comb begin
    if (int'(winner_index) >= (REQUESTS - 1)) begin
      pointer_next = '0;
    end
    else begin
      pointer_next = winner_index + arbiter_index_t'(1);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pointer <= '0;
    end
    else if (i_update && (i_request != '0)) begin
      pointer <= pointer_next;
    end
  end

endmodule

/* logic/arbiter_core.sv */
`timescale 1ns/1ps

module arbiter_core #(
  parameter int       REQUESTS       = 4,
  parameter bit       ONEHOT_GRANT   = 1,
  parameter bit [1:0] ENABLE_ARBITER = '1,
  parameter int       GRANT_WIDTH    = arbiter_pkg::calc_grant_width(REQUESTS, ONEHOT_GRANT)
)(
  input var logic    i_clk,
  input var logic    i_rst,
  arbiter_if.arbiter bus
);
  import arbiter_pkg::*;

  arbiter_mode_e       mode;
  logic [REQUESTS-1:0] owner;
  logic [REQUESTS-1:0] winner;
  logic                idle;
  logic                owner_freed;
  logic                update;

  // config only matters when both schemes are built in.
  always_comb begin
    if (ENABLE_ARBITER[ARBITER_ENABLE_FIXED] && ENABLE_ARBITER[ARBITER_ENABLE_RR]) begin
      mode = bus.arb_config.mode;
    end
    else if (ENABLE_ARBITER[ARBITER_ENABLE_RR]) begin
      mode = ARBITER_ROUND_ROBIN;
    end
    else begin
      mode = ARBITER_FIXED;
    end
  end

  assign idle        = (owner == '0);
  assign owner_freed = |(owner & bus.free);

  // free on a non-owner bit falls out of the mask above.
  assign update = (idle && (bus.request != '0)) || owner_freed;

  arbiter_select #(
    .REQUESTS (REQUESTS)
  ) u_select (
    .i_clk     (i_clk      ),
    .i_rst     (i_rst      ),
    .i_mode    (mode       ),
    .i_request (bus.request),
    .i_update  (update     ),
    .o_winner  (winner     )
  );

  // owner is held until freed.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      owner <= '0;
    end
    else if (update) begin
      owner <= winner;
    end
  end

  assign bus.active = !idle;

  if (ONEHOT_GRANT) begin : g_onehot
    assign bus.grant = GRANT_WIDTH'(owner);
  end
  else begin : g_binary
    arbiter_index_t owner_index;

    assign owner_index = onehot_to_index(ARBITER_MAX_REQUESTS'(owner));
    assign bus.grant   = GRANT_WIDTH'(owner_index);
  end

endmodule

/* logic/arbiter.sv */
`timescale 1ns/1ps

module arbiter #(
  parameter int       REQUESTS       = 4,
  parameter bit       ONEHOT_GRANT   = 1,
  parameter bit [1:0] ENABLE_ARBITER = '1,
  parameter int       GRANT_WIDTH    = arbiter_pkg::calc_grant_width(REQUESTS, ONEHOT_GRANT)
)(
  input var logic    i_clk,
  input var logic    i_rst,
  arbiter_if.arbiter bus
);

  if (REQUESTS > 1) begin : g_core
    arbiter_core #(
      .REQUESTS       (REQUESTS      ),
      .ONEHOT_GRANT   (ONEHOT_GRANT  ),
      .ENABLE_ARBITER (ENABLE_ARBITER),
      .GRANT_WIDTH    (GRANT_WIDTH   )
    ) u_core (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .bus   (bus  )
    );
  end
  else begin : g_single
    // nothing to arbitrate, the only requester always wins.
    always_comb begin
      if (ONEHOT_GRANT) begin
        bus.grant = GRANT_WIDTH'(bus.request);
      end
      else begin
        bus.grant = GRANT_WIDTH'(0);
      end
    end

    assign bus.active = bus.request[0];
  end

endmodule

/* logic/arbiter_top.sv */
`timescale 1ns/1ps

module arbiter_top #(
  parameter int       REQUESTS       = 4,
  parameter bit       ONEHOT_GRANT   = 1,
  parameter bit [1:0] ENABLE_ARBITER = '1,
  parameter int       GRANT_WIDTH    = arbiter_pkg::calc_grant_width(REQUESTS, ONEHOT_GRANT)
)(
  input  var logic                       i_clk,
  input  var logic                       i_rst,
  input  var arbiter_pkg::arbiter_mode_e i_mode,
  input  var logic [REQUESTS-1:0]        i_request,
  input  var logic [REQUESTS-1:0]        i_free,
  output var logic [GRANT_WIDTH-1:0]     o_grant,
  output var logic                       o_active
);
  import arbiter_pkg::*;

  arbiter_config_t cfg;

  arbiter_if #(
    .REQUESTS    (REQUESTS   ),
    .GRANT_WIDTH (GRANT_WIDTH)
  ) u_bus ();

  // pack run-time mode into the config word.
  always_comb begin
    cfg      = '0;
    cfg.mode = i_mode;
  end

  assign u_bus.arb_config = cfg;
  assign u_bus.request    = i_request;
  assign u_bus.free       = i_free;

  arbiter #(
    .REQUESTS       (REQUESTS      ),
    .ONEHOT_GRANT   (ONEHOT_GRANT  ),
    .ENABLE_ARBITER (ENABLE_ARBITER),
    .GRANT_WIDTH    (GRANT_WIDTH   )
  ) u_arbiter (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .bus   (u_bus)
  );

  assign o_grant  = u_bus.grant;
  assign o_active = u_bus.active;

endmodule

/* tests/arbiter_assert.sv */
`timescale 1ns/1ps

module arbiter_assert #(
  parameter int REQUESTS = 4
)(
  input var logic                i_clk,
  input var logic                i_rst,
  input var logic [REQUESTS-1:0] i_request,
  input var logic [REQUESTS-1:0] i_free,
  input var logic [REQUESTS-1:0] i_owner,
  input var logic                i_active
);

  // the owner mask is the one-hot grant.
  property owner_onehot;
    @(posedge i_clk) disable iff (i_rst)
      $onehot0(i_owner);
  endproperty

  // an idle arbiter grants one cycle after any request.
  property active_after_request;
    @(posedge i_clk) disable iff (i_rst)
      !i_active |=> (i_active == $past(i_request != '0));
  endproperty

  property owner_held;
    @(posedge i_clk) disable iff (i_rst)
      (i_owner != '0) && ((i_owner & i_free) == '0) |=> $stable(i_owner);
  endproperty

  assert property (owner_onehot)
    else $error("grant has more than one bit set");

  assert property (active_after_request)
    else $error("idle arbiter did not follow the requests one cycle later");

  assert property (owner_held)
    else $error("grant changed without a free from its owner");

endmodule

bind arbiter_core arbiter_assert #(
  .REQUESTS (REQUESTS)
) u_assert (
  .i_clk     (i_clk      ),
  .i_rst     (i_rst      ),
  .i_request (bus.request),
  .i_free    (bus.free   ),
  .i_owner   (owner      ),
  .i_active  (bus.active )
);

/* tests/arbiter_checker.sv */
`timescale 1ns/1ps

module arbiter_checker #(
  parameter int REQUESTS = 4
)(
  input  var logic                       i_clk,
  input  var logic                       i_rst,
  input  var arbiter_pkg::arbiter_mode_e i_mode,
  input  var logic [REQUESTS-1:0]        i_request,
  input  var logic [REQUESTS-1:0]        i_free,
  input  var logic [REQUESTS-1:0]        i_grant,
  input  var logic                       i_active,
  input  var logic                       i_stop,
  output var int                         o_errors,
  output var int                         o_checks,
  output var logic                       o_stopped
);
  import arbiter_pkg::*;

  // owner index, -1 while idle.
  int                  owner = -1;
  int                  pointer = 0;
  int                  errors = 0;
  int                  checks = 0;
  logic                stopped = 1'b0;
  logic                rearbitrate;
  logic [REQUESTS-1:0] expected_grant;

  assign o_errors  = errors;
  assign o_checks  = checks;
  assign o_stopped = stopped;

  // next owner under the given rule, -1 when nobody requests.
  function automatic int pick_winner(
    arbiter_mode_e       mode,
    logic [REQUESTS-1:0] request,
    int                  start
  );
    int candidate;
    int winner;
    winner = -1;
    for (int step = 0; step < REQUESTS; step++) begin
      if (mode == ARBITER_ROUND_ROBIN) candidate = (start + step) % REQUESTS;
      else candidate = step;
      if (winner < 0 && request[candidate]) winner = candidate;
    end
    return winner;
  endfunction

  always @(posedge i_clk) begin
    if (i_rst) begin
      owner   = -1;
      pointer = 0;
    end
    else begin
      if (owner < 0) rearbitrate = (i_request != '0);
      else rearbitrate = i_free[owner];
      if (rearbitrate) begin
        owner = pick_winner(i_mode, i_request, pointer);
        if (owner >= 0) pointer = (owner + 1) % REQUESTS;
      end
    end
  end

  // outputs are settled by the falling edge.
  always @(negedge i_clk) begin
    if (!stopped) begin
      expected_grant = '0;
      if (owner >= 0) expected_grant[owner] = 1'b1;
      checks++;
      if (i_grant !== expected_grant) begin
        $display("Mismatch at %0t: o_grant is %h, expected %h", $time, i_grant, expected_grant);
        errors++;
      end
      if (i_active !== (owner >= 0)) begin
        $display("Mismatch at %0t: o_active is %b, expected %b", $time, i_active, owner >= 0);
        errors++;
      end
      if (i_stop) stopped = 1'b1;
    end
  end

endmodule

/* tests/arbiter_tb.sv */
`timescale 1ns/1ps

module arbiter_tb;
  import arbiter_pkg::*;

  localparam int          REQUESTS      = 4;
  localparam int          RANDOM_CYCLES = 40;
  localparam int          STOP_TIMEOUT  = 20;
  localparam logic [31:0] SEED          = 32'h009f392d;

  logic                i_clk;
  logic                i_rst;
  arbiter_mode_e       i_mode;
  logic [REQUESTS-1:0] i_request;
  logic [REQUESTS-1:0] i_free;
  logic [REQUESTS-1:0] o_grant;
  logic                o_active;
  logic                stop;
  logic                stopped;
  int                  mismatches;
  int                  checks;
  int                  other_errors;
  int                  wait_cycles;
  logic [31:0]         lcg_state;

  arbiter_top #(
    .REQUESTS     (REQUESTS),
    .ONEHOT_GRANT (1       )
  ) UUT (
    .i_clk     (i_clk    ),
    .i_rst     (i_rst    ),
    .i_mode    (i_mode   ),
    .i_request (i_request),
    .i_free    (i_free   ),
    .o_grant   (o_grant  ),
    .o_active  (o_active )
  );

  arbiter_checker #(
    .REQUESTS (REQUESTS)
  ) u_checker (
    .i_clk     (i_clk     ),
    .i_rst     (i_rst     ),
    .i_mode    (i_mode    ),
    .i_request (i_request ),
    .i_free    (i_free    ),
    .i_grant   (o_grant   ),
    .i_active  (o_active  ),
    .i_stop    (stop      ),
    .o_errors  (mismatches),
    .o_checks  (checks    ),
    .o_stopped (stopped   )
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function automatic logic [31:0] next_random(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic drive_cycle(
    arbiter_mode_e       mode,
    logic [REQUESTS-1:0] request,
    logic [REQUESTS-1:0] free
  );
    @(posedge i_clk);
    i_mode    <= mode;
    i_request <= request;
    i_free    <= free;
  endtask

  task automatic play_trace();
    int         fd;
    int         fields;
    int         cycles;
    string      line;
    logic [3:0] mode_value;
    logic [3:0] request_value;
    logic [3:0] free_value;
    cycles = 0;
    fd = $fopen("tests/arbiter_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file tests/arbiter_trace.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") continue;
      fields = $sscanf(line, "%h %h %h", mode_value, request_value, free_value);
      if (fields == 3) begin
        drive_cycle(arbiter_mode_e'(mode_value[0]), request_value, free_value);
        cycles++;
      end
    end
    $fclose(fd);
    if (cycles == 0) begin
      $display("the trace file held no cycles");
      other_errors++;
    end
  endtask

  // free hits the current owner most of the time.
  task automatic play_random();
    logic [REQUESTS-1:0] free;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      @(negedge i_clk);
      lcg_state = next_random(lcg_state);
      free = (lcg_state[21:20] != 2'b00) ? o_grant : lcg_state[19:16];
      drive_cycle(arbiter_mode_e'(lcg_state[31]), lcg_state[27:24], free);
    end
  endtask

  task automatic finish_run();
    if (checks == 0) begin
      $display("the checker made no comparisons");
      other_errors++;
    end
    $display("checks %0d, mismatches %0d, other errors %0d",
             checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end
    else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  initial begin
    i_rst        = 1'b1;
    i_mode       = ARBITER_FIXED;
    i_request    = '0;
    i_free       = '0;
    stop         = 1'b0;
    other_errors = 0;
    lcg_state    = SEED;
    repeat (8) @(posedge i_clk);
    i_rst <= 1'b0;
    play_trace();
    play_random();
    drive_cycle(ARBITER_FIXED, '0, '0);
    @(posedge i_clk);
    stop <= 1'b1;
    wait_cycles = 0;
    while (!stopped && wait_cycles < STOP_TIMEOUT) begin
      @(posedge i_clk);
      wait_cycles++;
    end
    if (!stopped) begin
      $display("the checker did not finish within %0d cycles", STOP_TIMEOUT);
      other_errors++;
    end
    finish_run();
  end

endmodule

/* tests/arbiter_trace.txt */
# columns: mode (0 fixed, 1 round robin), request mask, free mask; all hex
# one line per clock cycle after reset
0 0 0
0 0 0
0 e 0
0 f 0
0 f 4
0 f 2
0 e 1
0 c 2
0 8 4
0 0 8
1 0 0
1 f 0
1 f 1
1 f 2
1 f 4
1 f 8
0 f 1
1 f 1
1 5 2
0 5 4
0 0 1
0 0 0
1 0 0

/* sim.f */
logic/arbiter_pkg.sv
logic/arbiter_if.sv
logic/arbiter_select.sv
logic/arbiter_core.sv
logic/arbiter.sv
logic/arbiter_top.sv
tests/arbiter_assert.sv
tests/arbiter_checker.sv
tests/arbiter_tb.sv
